// File: sources.f
write_engine_pkg.sv
write_data_fifo.sv
write_stream_control.sv
write_response_tracker.sv
write_engine_top.sv
tb_write_engine.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_write_engine
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_write_engine.sv
`default_nettype none

module tb_write_engine
	import write_engine_pkg::*;
();

	localparam int unsigned MAX_OUTSTANDING = 8;
	localparam int unsigned JOB_SIZE        = 40;
	// Two jobs of a few hundred cycles each, with a wide margin
	localparam int unsigned TIMEOUT_CYCLES  = 4000;

	logic             clock;
	logic             rstn;
	logic             enable;
	config_t          config_in;
	wed_request_t     wed_request;
	write_data_line_t write_data_in;
	logic             data_buffer_alfull;
	logic             command_buffer_alfull;
	write_command_t   write_command_out;
	write_data_line_t write_data_out;
	write_response_t  write_response_in;
	count_t           elements_done;
	logic             stream_finished;

	write_command_t   expected_cmd_q[$];
	write_data_line_t expected_line_q[$];
	count_t           response_size_q[$];
	int unsigned      response_due_q[$];
	int unsigned      cycle_count = 0;
	int unsigned      last_due;
	int unsigned      error_count;
	int unsigned      commands_seen;
	int unsigned      responses_sent;
	count_t           returned_sum;
	logic             alfull_seen;
	logic             finished_seen;

	write_engine_top #(
		.MAX_OUTSTANDING(MAX_OUTSTANDING),
		.FIFO_DEPTH     (16)
	) i_dut (
		.clock                 (clock),
		.rstn                  (rstn),
		.enable                (enable),
		.config_in             (config_in),
		.wed_request           (wed_request),
		.write_data_in         (write_data_in),
		.data_buffer_alfull    (data_buffer_alfull),
		.command_buffer_alfull (command_buffer_alfull),
		.write_command_out     (write_command_out),
		.write_data_out        (write_data_out),
		.write_response_in     (write_response_in),
		.elements_done         (elements_done),
		.stream_finished       (stream_finished)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// Expected command for one line of the job
	function automatic write_command_t expected_command(input addr_t base, input count_t offset,
		input count_t real_size, input logic write_ms);
		write_command_t cmd;
		cmd.valid      = 1'b1;
		cmd.command    = write_ms ? WRITE_MS : WRITE_NA;
		cmd.address    = base + addr_t'(offset) * addr_t'(ELEMENT_BYTES);
		cmd.size_bytes = bytes_t'(real_size * ELEMENT_BYTES);
		cmd.real_size  = real_size;
		return cmd;
	endfunction

	////////////////////
	// Output checker
	////////////////////

	always @(negedge clock) begin
		write_command_t   exp_cmd;
		write_data_line_t exp_line;
		int unsigned      due;
		if (rstn) begin
			if (write_command_out.valid || write_data_out.valid) begin
				assert (!command_buffer_alfull) else begin
					error_count++;
					$display("Command issued at %0t while back-pressure was held", $time);
				end
				assert (expected_cmd_q.size() != 0) else begin
					error_count++;
					$display("Command at %0t with no pushed line left to match", $time);
				end
				if (expected_cmd_q.size() != 0) begin
					exp_cmd  = expected_cmd_q.pop_front();
					exp_line = expected_line_q.pop_front();
					assert (write_command_out == exp_cmd) else begin
						error_count++;
						$display("Error: time %0t, write_command_out got %h expected %h",
							$time, write_command_out, exp_cmd);
					end
					assert (write_data_out == exp_line) else begin
						error_count++;
						$display("Error: time %0t, write_data_out got %h expected %h",
							$time, write_data_out, exp_line);
					end
				end
				commands_seen++;
				// Responses return in order, 1 to 6 cycles later
				due = cycle_count + 1 + $urandom_range(5);
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				response_size_q.push_back(write_command_out.real_size);
				response_due_q.push_back(due);
			end
			if (data_buffer_alfull) begin
				alfull_seen = 1'b1;
			end
			assert (commands_seen - responses_sent <= MAX_OUTSTANDING) else begin
				error_count++;
				$display("More than %0d commands outstanding at %0t", MAX_OUTSTANDING, $time);
			end
			if (stream_finished) begin
				assert (elements_done == JOB_SIZE) else begin
					error_count++;
					$display("Error: time %0t, elements_done got %0d expected %0d",
						$time, elements_done, JOB_SIZE);
				end
				assert (response_size_q.size() == 0) else begin
					error_count++;
					$display("Stream finished at %0t before all responses were returned", $time);
				end
				finished_seen = 1'b1;
			end
		end
	end

	// Responder
	initial begin
		write_response_in = '0;
		forever begin
			@(posedge clock);
			#1;
			write_response_in = '0;
			if (response_due_q.size() != 0 && response_due_q[0] <= cycle_count) begin
				void'(response_due_q.pop_front());
				write_response_in.valid     = 1'b1;
				write_response_in.real_size = response_size_q.pop_front();
				responses_sent++;
				returned_sum += write_response_in.real_size;
			end
		end
	end

	task automatic apply_reset();
		@(posedge clock);
		#1;
		rstn = 1'b0;
		expected_cmd_q.delete();
		expected_line_q.delete();
		response_size_q.delete();
		response_due_q.delete();
		commands_seen  = 0;
		responses_sent = 0;
		returned_sum   = '0;
		last_due       = 0;
		alfull_seen    = 1'b0;
		finished_seen  = 1'b0;
		repeat (3) @(posedge clock);
		#1;
		rstn = 1'b1;
	endtask

	task automatic check_reset_outputs();
		@(negedge clock);
		assert (write_command_out.valid == 1'b0 && write_data_out.valid == 1'b0) else begin
			error_count++;
			$display("Error: time %0t, output valid got %b/%b expected 0/0",
				$time, write_command_out.valid, write_data_out.valid);
		end
		assert (stream_finished == 1'b0 && elements_done == '0) else begin
			error_count++;
			$display("Error: time %0t, stream_finished/elements_done got %b/%0d expected 0/0",
				$time, stream_finished, elements_done);
		end
	endtask

	////////////////////
	// One job of JOB_SIZE elements
	////////////////////

	task automatic run_job(input logic write_ms, input addr_t base, input int unsigned hold_cycles);
		count_t           remaining;
		count_t           offset;
		count_t           line_size;
		write_data_line_t line;
		apply_reset();
		check_reset_outputs();
		@(posedge clock);
		#1;
		command_buffer_alfull = (hold_cycles != 0);
		config_in.valid       = 1'b1;
		config_in.write_ms    = write_ms;
		@(posedge clock);
		#1;
		config_in                  = '0;
		wed_request.valid          = 1'b1;
		wed_request.array_base     = base;
		wed_request.size_remaining = JOB_SIZE;
		@(posedge clock);
		#1;
		wed_request = '0;
		remaining   = JOB_SIZE;
		offset      = '0;
		fork
			begin
				while (remaining != 0) begin
					@(posedge clock);
					#1;
					write_data_in = '0;
					if (!data_buffer_alfull && $urandom_range(3) != 0) begin
						line_size      = (remaining == 1) ? 1 : count_t'(1 + $urandom_range(1));
						line.valid     = 1'b1;
						line.offset    = offset;
						line.real_size = line_size;
						line.data      = {$urandom(), $urandom()};
						write_data_in  = line;
						expected_cmd_q.push_back(
							expected_command(base, offset, line_size, write_ms));
						expected_line_q.push_back(line);
						offset    += line_size;
						remaining -= line_size;
					end
				end
				@(posedge clock);
				#1;
				write_data_in = '0;
			end
			begin
				if (hold_cycles != 0) begin
					repeat (hold_cycles) @(posedge clock);
					#1;
					assert (alfull_seen) else begin
						error_count++;
						$display("Data buffer almost-full never rose under back-pressure");
					end
					command_buffer_alfull = 1'b0;
				end
			end
		join
		while (!stream_finished) begin
			@(posedge clock);
			#1;
		end
		repeat (8) @(posedge clock);
		#1;
		assert (finished_seen) else begin
			error_count++;
			$display("Stream finished was never seen by the checker");
		end
		assert (elements_done == returned_sum && elements_done == JOB_SIZE) else begin
			error_count++;
			$display("Error: time %0t, elements_done got %0d expected %0d (job %0d)",
				$time, elements_done, returned_sum, JOB_SIZE);
		end
		assert (expected_cmd_q.size() == 0) else begin
			error_count++;
			$display("%0d pushed lines never came out as commands", expected_cmd_q.size());
		end
	endtask

	initial begin
		void'($urandom(14));
		error_count           = 0;
		rstn                  = 1'b0;
		enable                = 1'b1;
		config_in             = '0;
		wed_request           = '0;
		write_data_in         = '0;
		command_buffer_alfull = 1'b0;
		run_job(1'b0, 64'h0000_0040_1000_0000, 0);
		run_job(1'b1, 64'h0000_7f00_0000_0800, 50);
		$display("Checks done, errors: %0d", error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout, the run did not complete within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks done, errors: %0d", error_count);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: write_engine_top.sv
`default_nettype none

module write_engine_top
	import write_engine_pkg::*;
#(
	parameter int unsigned MAX_OUTSTANDING = 8,
	parameter int unsigned FIFO_DEPTH      = 16
) (
	input  wire logic             clock,
	input  wire logic             rstn,
	input  wire logic             enable,
	input  wire config_t          config_in,
	input  wire wed_request_t     wed_request,
	input  wire write_data_line_t write_data_in,
	output logic                  data_buffer_alfull,
	input  wire logic             command_buffer_alfull,
	output write_command_t        write_command_out,
	output write_data_line_t      write_data_out,
	input  wire write_response_t  write_response_in,
	output count_t                elements_done,
	output logic                  stream_finished
);

	write_data_line_t head_line;
	logic             fifo_empty;
	logic             pop;
	write_command_t   command_stage;
	write_data_line_t data_stage;
	logic             response_pulse;

	write_data_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_data_fifo (
		.clock     (clock),
		.rstn      (rstn),
		.push      (write_data_in.valid),
		.push_line (write_data_in),
		.pop       (pop),
		.head_line (head_line),
		.empty     (fifo_empty),
		.full      (),
		.alfull    (data_buffer_alfull)
	);

	write_stream_control #(
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) i_control (
		.clock                 (clock),
		.rstn                  (rstn),
		.enable                (enable),
		.config_in             (config_in),
		.wed_request           (wed_request),
		.head_line             (head_line),
		.fifo_empty            (fifo_empty),
		.command_buffer_alfull (command_buffer_alfull),
		.response_pulse        (response_pulse),
		.pop                   (pop),
		.command_stage         (command_stage),
		.data_stage            (data_stage),
		.stream_finished       (stream_finished)
	);

	////////////////////
	// Output register
	////////////////////

	// Second stage after the pop, holds while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command_out <= '0;
			write_data_out    <= '0;
		end else if (enable) begin
			write_command_out <= command_stage;
			write_data_out    <= data_stage;
		end
	end

	write_response_tracker i_tracker (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.response_in    (write_response_in),
		.response_pulse (response_pulse),
		.elements_done  (elements_done)
	);

endmodule

`default_nettype wire

// File: write_response_tracker.sv
`default_nettype none

module write_response_tracker
	import write_engine_pkg::*;
(
	input  wire logic            clock,
	input  wire logic            rstn,
	input  wire logic            enable,
	input  wire write_response_t response_in,
	output logic                 response_pulse,
	output count_t               elements_done
);

	write_response_t response_reg;

	// Cleared while disabled so a held response is not counted twice
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_reg <= '0;
		end else if (enable) begin
			response_reg <= response_in;
		end else begin
			response_reg <= '0;
		end
	end

	assign response_pulse = response_reg.valid;

	////////////////////
	// Running total
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			elements_done <= '0;
		end else if (response_reg.valid) begin
			elements_done <= elements_done + response_reg.real_size;
		end
	end

endmodule

`default_nettype wire

// File: write_stream_control.sv
`default_nettype none

module write_stream_control
	import write_engine_pkg::*;
#(
	parameter int unsigned MAX_OUTSTANDING = 8
) (
	input  wire logic             clock,
	input  wire logic             rstn,
	input  wire logic             enable,
	input  wire config_t          config_in,
	input  wire wed_request_t     wed_request,
	input  wire write_data_line_t head_line,
	input  wire logic             fifo_empty,
	input  wire logic             command_buffer_alfull,
	input  wire logic             response_pulse,
	output logic                  pop,
	output write_command_t        command_stage,
	output write_data_line_t      data_stage,
	output logic                  stream_finished
);

	localparam int unsigned BATCH_W = $clog2(MAX_OUTSTANDING + 1);

	typedef logic [BATCH_W-1:0] batch_count_t;

	stream_state_e state;
	stream_state_e next_state;
	wed_request_t  wed_latched;
	addr_t         array_base;
	count_t        size_remaining;
	logic          write_ms;
	batch_count_t  issue_count;
	batch_count_t  response_count;
	logic          window_open;
	command_e      command_kind;

	// Command kind follows the latched configuration
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_ms <= 1'b0;
		end else if (config_in.valid) begin
			write_ms <= config_in.write_ms;
		end
	end

	assign command_kind = write_ms ? WRITE_MS : WRITE_NA;

	////////////////////
	// Stream FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= RESET;
		end else if (enable) begin
			state <= next_state;
		end
	end

	assign window_open = (issue_count < batch_count_t'(MAX_OUTSTANDING)) && (size_remaining != '0);

	always_comb begin
		next_state = state;
		case (state)
			RESET:   next_state = IDLE;
			IDLE:    if (wed_request.valid) next_state = SET;
			SET:     next_state = START;
			START:   next_state = REQ;
			REQ:     if (!window_open) next_state = PENDING;
			PENDING: if (response_count == issue_count) next_state = DONE;
			DONE:    next_state = (size_remaining != '0) ? START : FINAL;
			FINAL:   next_state = FINAL;
			default: next_state = RESET;
		endcase
	end

	assign stream_finished = (state == FINAL);

	assign pop = enable && (state == REQ) && !fifo_empty && !command_buffer_alfull && window_open;

	////////////////////
	// Descriptor and batch counters
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched    <= '0;
			array_base     <= '0;
			size_remaining <= '0;
		end else if (enable) begin
			if (state == IDLE && wed_request.valid) begin
				wed_latched <= wed_request;
			end
			if (state == SET) begin
				array_base     <= wed_latched.array_base;
				size_remaining <= wed_latched.size_remaining;
			end else if (pop) begin
				// Saturate on a short last line
				if (head_line.real_size >= size_remaining) begin
					size_remaining <= '0;
				end else begin
					size_remaining <= size_remaining - head_line.real_size;
				end
			end
		end
	end

	// Responses still count while enable is low
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_count    <= '0;
			response_count <= '0;
		end else if (state == START) begin
			issue_count    <= '0;
			response_count <= '0;
		end else begin
			if (pop) begin
				issue_count <= issue_count + 1'b1;
			end
			if (response_pulse) begin
				response_count <= response_count + 1'b1;
			end
		end
	end

	////////////////////
	// Command formation
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_stage <= '0;
			data_stage    <= '0;
		end else if (enable) begin
			if (pop) begin
				command_stage.valid      <= 1'b1;
				command_stage.command    <= command_kind;
				command_stage.address    <= array_base +
					addr_t'(head_line.offset) * addr_t'(ELEMENT_BYTES);
				command_stage.size_bytes <= bytes_t'(head_line.real_size * ELEMENT_BYTES);
				command_stage.real_size  <= head_line.real_size;
				data_stage               <= head_line;
				data_stage.valid         <= 1'b1;
			end else begin
				command_stage <= '0;
				data_stage    <= '0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) response_count <= issue_count)
		else $error("batch response count exceeds batch issue count");

	assert property (@(posedge clock) disable iff (!rstn)
		pop |-> (head_line.real_size >= 1) && (head_line.real_size <= MAX_LINE_ELEMENTS))
		else $error("popped line carries an illegal element count");

endmodule

`default_nettype wire

// File: write_data_fifo.sv
`default_nettype none

module write_data_fifo
	import write_engine_pkg::*;
#(
	parameter int unsigned FIFO_DEPTH = 16
) (
	input  wire logic             clock,
	input  wire logic             rstn,
	input  wire logic             push,
	input  wire write_data_line_t push_line,
	input  wire logic             pop,
	output write_data_line_t      head_line,
	output logic                  empty,
	output logic                  full,
	output logic                  alfull
);

	localparam int unsigned PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int unsigned COUNT_W  = $clog2(FIFO_DEPTH + 1);
	localparam int unsigned HEADROOM = FIFO_DEPTH / 4;

	write_data_line_t   storage [FIFO_DEPTH];
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W-1:0]   wr_ptr;
	logic [COUNT_W-1:0] occupancy;
	logic               do_push;
	logic               do_pop;

	// Wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Lines pushed while full are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			storage[wr_ptr] <= push_line;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr    <= '0;
			wr_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	////////////////////
	// Status flags
	////////////////////

	assign empty  = (occupancy == '0);
	assign full   = (occupancy == COUNT_W'(FIFO_DEPTH));
	// Raised once the free slots drop to the headroom
	assign alfull = ((COUNT_W'(FIFO_DEPTH) - occupancy) <= COUNT_W'(HEADROOM));

	assign head_line = empty ? '0 : storage[rd_ptr];

	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("write data line pushed into a full FIFO");

	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("pop requested from an empty write data FIFO");

endmodule

`default_nettype wire

// File: write_engine_pkg.sv
`default_nettype none

package write_engine_pkg;

	////////////////////
	// Widths and basic types
	////////////////////

	localparam int unsigned ADDR_WIDTH  = 64;
	localparam int unsigned COUNT_WIDTH = 32;
	localparam int unsigned DATA_WIDTH  = 64;
	localparam int unsigned BYTES_WIDTH = 12;

	typedef logic [ADDR_WIDTH-1:0]  addr_t;
	typedef logic [COUNT_WIDTH-1:0] count_t;
	typedef logic [DATA_WIDTH-1:0]  data_t;
	typedef logic [BYTES_WIDTH-1:0] bytes_t;

	// Element geometry
	localparam int unsigned ELEMENT_BYTES     = 4;
	localparam int unsigned MAX_LINE_ELEMENTS = 2;

	////////////////////
	// Enums
	////////////////////

	typedef enum logic [1:0] {
		WRITE_NA = 2'd0,
		WRITE_MS = 2'd1
	} command_e;

	typedef enum logic [2:0] {
		RESET,
		IDLE,
		SET,
		START,
		REQ,
		PENDING,
		DONE,
		FINAL
	} stream_state_e;

	////////////////////
	// Bundles
	////////////////////

	typedef struct packed {
		logic valid;
		logic write_ms;
	} config_t;

	typedef struct packed {
		logic   valid;
		addr_t  array_base;
		count_t size_remaining;
	} wed_request_t;

	// Offset is counted in elements, not bytes
	typedef struct packed {
		logic   valid;
		count_t offset;
		count_t real_size;
		data_t  data;
	} write_data_line_t;

	typedef struct packed {
		logic     valid;
		command_e command;
		addr_t    address;
		bytes_t   size_bytes;
		count_t   real_size;
	} write_command_t;

	typedef struct packed {
		logic   valid;
		count_t real_size;
	} write_response_t;

endpackage

`default_nettype wire
